// ==== Bender.yml ====
package:
  name: dragon_game

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dragonPkg.sv
      - frameTicker.sv
      - dragonHead.sv
      - dragonBody.sv
      - collisionCheck.sv
      - dragonGame.sv
      - target: simulation
        files:
          - tbClock.sv
          - tbDragonGame.sv

// ==== collisionCheck.sv ====
/* collision check
   tests the moved head against food and visible segments, keeps the score */
`timescale 1ns/1ns
`include "dragon_params.svh"

module collisionCheck import dragonPkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  moved,
    input  segT   head,
    input  segT   seg1,
    input  segT   seg2,
    input  segT   seg3,
    input  segT   seg4,
    input  segT   seg5,
    input  segT   seg6,
    input  segT   seg7,
    input  maskT  displayEn,
    input  posT   food,
    output lenOpT lenOp,
    output scoreT score
);

    segT segs [`NUM_SEGMENTS];
    posT headPos;
    logic bodyHit;
    logic foodHit;
    lenOpT nextOp;

    assign segs    = '{seg1, seg2, seg3, seg4, seg5, seg6, seg7};
    assign headPos = head[2*`GRID_BITS-1:0];  // orientation ignored
    assign foodHit = (headPos == food);

    // hidden segments never count as a hit
    always_comb begin
        bodyHit = 1'b0;
        for (int i = 0; i < `NUM_SEGMENTS; i++) begin
            if (displayEn[i] && (segs[i][2*`GRID_BITS-1:0] == headPos)) begin
                bodyHit = 1'b1;
            end
        end
    end

    always_comb begin
        if (!moved) begin
            nextOp = MOVE;
        end else if (bodyHit) begin
            nextOp = SHRINK;        // body wins over food
        end else if (foodHit) begin
            nextOp = GROW;
        end else begin
            nextOp = MOVE;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            lenOp <= MOVE;
            score <= '0;
        end else begin
            lenOp <= nextOp;        // one-cycle command
            if (nextOp == GROW) begin
                score <= score + 1'b1;  // keeps counting past full mask
            end
        end
    end

    // mask updates must stay tied to head moves
    lenOpAfterMove: assert property (
        @(posedge clk) disable iff (!reset)
        (lenOp != MOVE) |-> $past(moved)
    );

endmodule

// ==== compile.f ====
+incdir+.
dragonPkg.sv
frameTicker.sv
dragonHead.sv
dragonBody.sv
collisionCheck.sv
dragonGame.sv
tbClock.sv
tbDragonGame.sv

// ==== dragonBody.sv ====
/* dragon body
   segment queue that trails the head, plus the visibility mask */
`timescale 1ns/1ns
`include "dragon_params.svh"

module dragonBody import dragonPkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  moveStrobe,
    input  segT   head,
    input  lenOpT lenOp,
    output segT   seg1,
    output segT   seg2,
    output segT   seg3,
    output segT   seg4,
    output segT   seg5,
    output segT   seg6,
    output segT   seg7,
    output maskT  displayEn
);

    segT queue [`NUM_SEGMENTS];  // index 0 nearest the head

    // shift on the same edge the head moves, so seg1 gets the old head
    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < `NUM_SEGMENTS; i++) begin
                queue[i] <= '0;
            end
        end else if (moveStrobe) begin
            queue[0] <= head;
            for (int i = 1; i < `NUM_SEGMENTS; i++) begin
                queue[i] <= queue[i-1];
            end
        end
    end

    assign seg1 = queue[0];
    assign seg2 = queue[1];
    assign seg3 = queue[2];
    assign seg4 = queue[3];
    assign seg5 = queue[4];
    assign seg6 = queue[5];
    assign seg7 = queue[6];

    always_ff @(posedge clk) begin
        if (!reset) begin
            displayEn <= '0;
        end else begin
            case (lenOp)
                GROW:    displayEn <= (displayEn << 1) | maskT'(1);  // top bit drops, saturates
                SHRINK:  displayEn <= displayEn >> 1;
                MOVE:    displayEn <= displayEn;
                IDLE:    displayEn <= displayEn;
                default: displayEn <= displayEn;
            endcase
        end
    end

    // visible segments always form an unbroken run from the head
    maskContiguous: assert property (
        @(posedge clk) disable iff (!reset)
        (displayEn & maskT'(displayEn + 1'b1)) == '0
    );

endmodule

// ==== dragonGame.sv ====
/* dragon game core
   ties the frame ticker, head, body and collision checker together */
`timescale 1ns/1ns

module dragonGame import dragonPkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  vsync,
    input  dirT   steer,
    input  posT   food,
    output segT   head,
    output segT   seg1,
    output segT   seg2,
    output segT   seg3,
    output segT   seg4,
    output segT   seg5,
    output segT   seg6,
    output segT   seg7,
    output maskT  displayEn,
    output scoreT score
);

    logic moveStrobe;
    logic moved;
    lenOpT lenOp;

    frameTicker ticker (
        .clk        (clk),
        .reset      (reset),
        .vsync      (vsync),
        .moveStrobe (moveStrobe)
    );

    dragonHead headUnit (
        .clk        (clk),
        .reset      (reset),
        .moveStrobe (moveStrobe),
        .steer      (steer),
        .head       (head),
        .moved      (moved)
    );

    dragonBody body (
        .clk        (clk),
        .reset      (reset),
        .moveStrobe (moveStrobe),
        .head       (head),
        .lenOp      (lenOp),
        .seg1       (seg1),
        .seg2       (seg2),
        .seg3       (seg3),
        .seg4       (seg4),
        .seg5       (seg5),
        .seg6       (seg6),
        .seg7       (seg7),
        .displayEn  (displayEn)
    );

    collisionCheck collision (
        .clk        (clk),
        .reset      (reset),
        .moved      (moved),
        .head       (head),
        .seg1       (seg1),
        .seg2       (seg2),
        .seg3       (seg3),
        .seg4       (seg4),
        .seg5       (seg5),
        .seg6       (seg6),
        .seg7       (seg7),
        .displayEn  (displayEn),
        .food       (food),
        .lenOp      (lenOp),
        .score      (score)
    );

endmodule

// ==== dragonHead.sv ====
/* dragon head
   steers and steps the head one cell per move strobe on a wrapping grid */
`timescale 1ns/1ns
`include "dragon_params.svh"

module dragonHead import dragonPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic moveStrobe,
    input  dirT  steer,
    output segT  head,
    output logic moved
);

    headStateT state;
    dirT dir;
    dirT nextDir;
    posT pos;
    logic [`GRID_BITS-1:0] row;
    logic [`GRID_BITS-1:0] col;
    logic [`GRID_BITS-1:0] nextRow;
    logic [`GRID_BITS-1:0] nextCol;

    assign row = pos[2*`GRID_BITS-1:`GRID_BITS];
    assign col = pos[`GRID_BITS-1:0];

    // opposite direction differs only in the upper encoding bit
    assign nextDir = (steer == dirT'(dir ^ 2'b10)) ? dir : steer;

    always_comb begin
        nextRow = row;
        nextCol = col;
        case (nextDir)
            UP:    nextRow = row - 1'b1;  // wraps naturally at the grid edge
            DOWN:  nextRow = row + 1'b1;
            RIGHT: nextCol = col + 1'b1;
            LEFT:  nextCol = col - 1'b1;
            default: begin
                nextRow = row;
                nextCol = col;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= HEAD_RUN;
            dir   <= RIGHT;
            // grid centre
            pos   <= {1'b1, {(`GRID_BITS-1){1'b0}}, 1'b1, {(`GRID_BITS-1){1'b0}}};
        end else if (moveStrobe) begin
            state <= HEAD_HOLD;
            dir   <= nextDir;
            pos   <= {nextRow, nextCol};
        end else begin
            state <= HEAD_RUN;
        end
    end

    assign head  = {dir, pos};
    assign moved = (state == HEAD_HOLD);  // collision check samples here

    movedFollowsStrobe: assert property (
        @(posedge clk) disable iff (!reset)
        moved == $past(moveStrobe)
    );

endmodule

// ==== dragonPkg.sv ====
/* dragon game types
   positions, segments, masks, length commands and FSM states */
package dragonPkg;

    `include "dragon_params.svh"

    typedef logic [2*`GRID_BITS-1:0] posT;    // row in upper half, column in lower
    typedef logic [2*`GRID_BITS+1:0] segT;    // orientation on top, position below
    typedef logic [`NUM_SEGMENTS-1:0] maskT;  // bit 0 nearest the head
    typedef logic [`SCORE_BITS-1:0] scoreT;

    typedef enum logic [1:0] {
        UP    = 2'd0,
        RIGHT = 2'd1,
        DOWN  = 2'd2,
        LEFT  = 2'd3
    } dirT;

    typedef enum logic [1:0] {
        MOVE   = 2'd0,  // no change
        GROW   = 2'd1,
        SHRINK = 2'd2,
        IDLE   = 2'd3   // no change
    } lenOpT;

    typedef enum logic {HEAD_RUN, HEAD_HOLD} headStateT;
    typedef enum logic {TICK_COUNT, TICK_FIRE} tickStateT;

endpackage

// ==== dragon_cases.txt ====
# steer food head displayEn score, all hex, one move per line
# steer 0 up 1 right 2 down 3 left; head is orientation then row and column
# square loop with nothing visible, last move lands on a hidden segment
2 00 298 00 00
0 00 2a8 00 00
3 00 3a7 00 00
0 00 097 00 00
1 00 198 00 00
# eat along row 9, mask saturates, right edge wraps
1 99 199 01 01
1 9a 19a 03 02
3 9b 19b 07 03
1 9c 19c 0f 04
1 9d 19d 1f 05
1 9e 19e 3f 06
1 9f 19f 7f 07
1 90 190 7f 08
# left wrap then run into a visible segment
0 55 080 7f 08
3 55 38f 7f 08
2 55 29f 3f 08
# down column f with one more meal, bottom and top wraps
2 55 2af 3f 08
2 55 2bf 3f 08
2 cf 2cf 7f 09
0 55 2df 7f 09
2 55 2ef 7f 09
2 55 2ff 7f 09
2 55 20f 7f 09
3 55 30e 7f 09
0 55 0fe 7f 09

// ==== dragon_params.svh ====
/* dragon game parameters
   grid size, body length, move rate and score width */
`ifndef DRAGON_PARAMS_SVH
`define DRAGON_PARAMS_SVH

// grid is 2**GRID_BITS cells on each axis
`define GRID_BITS 4

// body segments behind the head
`define NUM_SEGMENTS 7

// vsync pulses between two head moves
`define MOVE_FRAMES 3

// score counter width
`define SCORE_BITS 8

`endif

// ==== frameTicker.sv ====
/* frame ticker
   divides vsync pulses down to a one-cycle move strobe */
`timescale 1ns/1ns
`include "dragon_params.svh"

module frameTicker import dragonPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic vsync,
    output logic moveStrobe
);

    localparam int CountBits = $clog2(`MOVE_FRAMES + 1);

    tickStateT state;
    logic [CountBits-1:0] frameCount;
    logic lastFrame;

    assign lastFrame = (frameCount == CountBits'(`MOVE_FRAMES - 1)); // wrap point

    always_ff @(posedge clk) begin
        if (!reset) begin
            state      <= TICK_COUNT;
            frameCount <= '0;
        end else begin
            state <= TICK_COUNT;                       // fire lasts one cycle
            if (vsync) begin
                if (lastFrame) begin
                    frameCount <= '0;
                    state      <= TICK_FIRE;
                end else begin
                    frameCount <= frameCount + 1'b1;
                end
            end
        end
    end

    assign moveStrobe = (state == TICK_FIRE);

    // downstream expects isolated strobes, one move per frame group
    strobeSingle: assert property (
        @(posedge clk) disable iff (!reset)
        moveStrobe |=> !moveStrobe
    );

endmodule

// ==== tbClock.sv ====
/* testbench clock and reset
   20 ns clock, active low reset held for the first 4 cycles */
`timescale 1ns/1ns

module tbClock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        reset = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b1;
    end

endmodule

// ==== tbDragonGame.sv ====
/* dragon game testbench
   replays move cases from a file and checks them against a reference model */
`timescale 1ns/1ns
`include "dragon_params.svh"

module tbDragonGame import dragonPkg::*; ();

    localparam int GridSize = 1 << `GRID_BITS;

    logic clk;
    logic reset;
    logic vsync;
    dirT steer;
    posT food;
    segT head;
    segT seg1, seg2, seg3, seg4, seg5, seg6, seg7;
    maskT displayEn;
    scoreT score;

    // one entry per case line
    dirT   caseSteer [$];
    posT   caseFood [$];
    segT   caseHead [$];
    maskT  caseMask [$];
    scoreT caseScore [$];

    // reference model of the game state
    dirT   mDir;
    int    mRow;
    int    mCol;
    int    mLen;                       // visible segment count
    scoreT mScore;
    segT   mQueue [`NUM_SEGMENTS];     // index 0 nearest the head

    int cycleCount = 0;
    int cycleLimit = 50;

    tbClock clockGen (
        .clk   (clk),
        .reset (reset)
    );

    dragonGame DUT (
        .clk       (clk),
        .reset     (reset),
        .vsync     (vsync),
        .steer     (steer),
        .food      (food),
        .head      (head),
        .seg1      (seg1),
        .seg2      (seg2),
        .seg3      (seg3),
        .seg4      (seg4),
        .seg5      (seg5),
        .seg6      (seg6),
        .seg7      (seg7),
        .displayEn (displayEn),
        .score     (score)
    );

    function automatic dirT reverseOf(input dirT d);
        case (d)
            UP:      return DOWN;
            DOWN:    return UP;
            RIGHT:   return LEFT;
            default: return RIGHT;
        endcase
    endfunction

    function automatic segT modelHead();
        posT pos;
        pos = posT'((mRow << `GRID_BITS) | mCol);  // row in upper half
        return {mDir, pos};
    endfunction

    function automatic maskT modelMask();
        return maskT'((1 << mLen) - 1);
    endfunction

    task automatic abortRun();
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkSeg(input string name, input segT actual, input segT expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkMask(input string name, input maskT actual, input maskT expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkScore(input string name, input scoreT actual, input scoreT expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            abortRun();
        end
    endtask

    // segments always come from the model
    task automatic checkState(input segT expHead, input maskT expMask, input scoreT expScore);
        checkSeg("head", head, expHead);
        checkSeg("seg1", seg1, mQueue[0]);
        checkSeg("seg2", seg2, mQueue[1]);
        checkSeg("seg3", seg3, mQueue[2]);
        checkSeg("seg4", seg4, mQueue[3]);
        checkSeg("seg5", seg5, mQueue[4]);
        checkSeg("seg6", seg6, mQueue[5]);
        checkSeg("seg7", seg7, mQueue[6]);
        checkMask("displayEn", displayEn, expMask);
        checkScore("score", score, expScore);
    endtask

    task automatic applyMove(input dirT steerIn, input posT foodIn);
        posT newPos;
        logic hit;
        for (int i = `NUM_SEGMENTS - 1; i > 0; i--) begin
            mQueue[i] = mQueue[i-1];
        end
        mQueue[0] = modelHead();  // old head enters the body
        if (steerIn != reverseOf(mDir)) begin
            mDir = steerIn;
        end
        case (mDir)
            UP:      mRow = (mRow + GridSize - 1) % GridSize;
            DOWN:    mRow = (mRow + 1) % GridSize;
            RIGHT:   mCol = (mCol + 1) % GridSize;
            default: mCol = (mCol + GridSize - 1) % GridSize;
        endcase
        newPos = posT'((mRow << `GRID_BITS) | mCol);
        hit = 1'b0;
        for (int i = 0; i < mLen; i++) begin
            if (mQueue[i][2*`GRID_BITS-1:0] == newPos) begin
                hit = 1'b1;
            end
        end
        if (hit) begin
            mLen = (mLen > 0) ? mLen - 1 : 0;
        end else if (newPos == foodIn) begin
            mLen = (mLen < `NUM_SEGMENTS) ? mLen + 1 : mLen;  // score still counts when full
            mScore = mScore + 1'b1;
        end
    endtask

    task automatic loadCases();
        int fd;
        int fields;
        string line;
        logic [31:0] vSteer, vFood, vHead, vMask, vScore;
        fd = $fopen("dragon_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open dragon_cases.txt for reading");
            abortRun();
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;  // blank or comment line
                end
                fields = $sscanf(line, "%h %h %h %h %h", vSteer, vFood, vHead, vMask, vScore);
                if (fields != 5) begin
                    $display("case file line has %0d fields instead of 5: %s", fields, line);
                    abortRun();
                end else begin
                    caseSteer.push_back(dirT'(vSteer[1:0]));
                    caseFood.push_back(posT'(vFood));
                    caseHead.push_back(segT'(vHead));
                    caseMask.push_back(maskT'(vMask));
                    caseScore.push_back(scoreT'(vScore));
                end
            end
            $fclose(fd);
            if (caseSteer.size() == 0) begin
                $display("the case file holds no cases");
                abortRun();
            end else begin
                cycleLimit = 30 * caseSteer.size() + 50;
            end
        end
    endtask

    task automatic runCase(input int idx);
        @(posedge clk);
        steer <= caseSteer[idx];
        food  <= caseFood[idx];
        for (int p = 1; p <= `MOVE_FRAMES; p++) begin
            @(posedge clk);
            vsync <= 1'b1;
            @(posedge clk);
            vsync <= 1'b0;
            repeat (4) @(posedge clk);  // move, collision and mask all settled
            @(negedge clk);
            if (p < `MOVE_FRAMES) begin
                checkState(modelHead(), modelMask(), mScore);  // nothing moves yet
            end
        end
        applyMove(caseSteer[idx], caseFood[idx]);
        if (modelHead() !== caseHead[idx] || modelMask() !== caseMask[idx]
                || mScore !== caseScore[idx]) begin
            $display("case %0d in the file does not agree with the reference model", idx + 1);
            abortRun();
        end
        checkState(caseHead[idx], caseMask[idx], caseScore[idx]);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, the case run did not finish", cycleCount);
            abortRun();
        end
    end

    initial begin
        vsync  = 1'b0;
        steer  = RIGHT;
        food   = '0;
        mDir   = RIGHT;  // reset head sits at grid centre
        mRow   = GridSize / 2;
        mCol   = GridSize / 2;
        mLen   = 0;
        mScore = '0;
        for (int i = 0; i < `NUM_SEGMENTS; i++) begin
            mQueue[i] = '0;
        end
        loadCases();
        wait (reset === 1'b1);
        @(negedge clk);
        checkState(modelHead(), modelMask(), mScore);  // reset values
        for (int i = 0; i < caseSteer.size(); i++) begin
            runCase(i);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule
